// File: Makefile
TOP := fsa_overlay_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+10

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: hdl/column_bound_ram.sv
`timescale 1ns/1ns
`include "fsa_params.svh"

module column_bound_ram
	import fsa_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   wr_en,
	input  logic [`FSA_IMG_WW-1:0] wr_addr,
	input  col_bound_t             wr_data,
	input  logic [`FSA_IMG_WW-1:0] rd_addr,
	output col_bound_t             bound
);

	localparam int ENTRIES = 1 << `FSA_IMG_WW;

	col_bound_t             mem [0:ENTRIES-1];
	logic [`FSA_IMG_WW-1:0] addr_q;
	col_bound_t             rd_q;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// address, array and output registers give the stage 3 alignment
	always_ff @(posedge clk) begin
		if (!resetn) begin
			addr_q <= '0;
		end else begin
			addr_q <= rd_addr;
		end
	end

	// old data on a same-cycle write
	always_ff @(posedge clk) begin
		rd_q <= mem[addr_q];
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			bound <= '0;
		end else begin
			bound <= rd_q;
		end
	end

endmodule

// File: hdl/corner_overlay_pipe.sv
`timescale 1ns/1ns
`include "fsa_params.svh"

module corner_overlay_pipe
	import fsa_pkg::*;
(
	input  logic         clk,
	input  logic         resetn,
	input  logic         accept,
	input  pix_beat_t    beat,
	input  pix_pos_t     pos,
	input  logic         frame_overlay,
	input  corner_geom_t geom,
	input  col_bound_t   bound,
	output logic         fifo_wr,
	output out_word_t    fifo_word
);

	pix_beat_t              beat_q [1:4];
	pix_pos_t               pos_q  [1:3];
	logic [4:1]             vld_q;
	logic [4:1]             ovl_q;
	logic [`FSA_IMG_WW-1:0] px;
	logic [`FSA_IMG_HW-1:0] py;
	logic                   lt_hit;
	logic                   lb_hit;
	logic                   rt_hit;
	logic                   rb_hit;
	logic                   lt_q;
	logic                   lb_q;
	logic                   rt_q;
	logic                   rb_q;
	logic                   use_overlay;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[3:1], accept};
		end
	end

	// stages 1 to 4 payload
	always_ff @(posedge clk) begin
		beat_q[1] <= beat;
		pos_q[1]  <= pos;
		for (int i = 2; i <= 3; i++) begin
			beat_q[i] <= beat_q[i-1];
			pos_q[i]  <= pos_q[i-1];
		end
		beat_q[4] <= beat_q[3];
		ovl_q     <= {ovl_q[3:1], frame_overlay};
	end

	// bound is valid for the stage 3 column
	assign px = pos_q[3].x;
	assign py = pos_q[3].y;

	assign lt_hit = geom.left.corner_valid
		&& (py >= geom.left.top_y) && (py < bound.top)
		&& (px > geom.left.top_x) && (px <= geom.left.edge_x);

	assign lb_hit = geom.left.corner_valid
		&& (py <= geom.left.bot_y) && (py > bound.bot)
		&& (px > geom.left.bot_x) && (px <= geom.left.edge_x);

	// right side mirrored about the edge
	assign rt_hit = geom.right.corner_valid
		&& (py >= geom.right.top_y) && (py < bound.top)
		&& (px >= geom.right.edge_x) && (px < geom.right.top_x);

	assign rb_hit = geom.right.corner_valid
		&& (py <= geom.right.bot_y) && (py > bound.bot)
		&& (px >= geom.right.edge_x) && (px < geom.right.bot_x);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			lt_q <= 1'b0;
			lb_q <= 1'b0;
			rt_q <= 1'b0;
			rb_q <= 1'b0;
		end else begin
			lt_q <= lt_hit;
			lb_q <= lb_hit;
			rt_q <= rt_hit;
			rb_q <= rb_hit;
		end
	end

	assign use_overlay = ovl_q[4]
		&& ((geom.left.valid && (lt_q || lb_q))
		|| (geom.right.valid && (rt_q || rb_q)));

	// stage 5 into the fifo
	always_ff @(posedge clk) begin
		if (!resetn) begin
			fifo_wr <= 1'b0;
		end else begin
			fifo_wr <= vld_q[4];
		end
	end

	always_ff @(posedge clk) begin
		fifo_word.user <= beat_q[4].user;
		fifo_word.last <= beat_q[4].last;
		if (use_overlay) begin
			fifo_word.data <= `FSA_OVERLAY_COLOR;
		end else begin
			fifo_word.data <= {3{beat_q[4].data}};
		end
	end

endmodule

// File: hdl/frame_ctrl_fsm.sv
`timescale 1ns/1ns
`include "fsa_params.svh"

module frame_ctrl_fsm
	import fsa_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   fsync,
	input  logic                   en_overlay,
	input  corner_geom_t           geom_in,
	input  logic [`FSA_IMG_HW-1:0] height,
	input  logic                   accept,
	input  pix_beat_t              beat,
	input  pix_pos_t               pos,
	output corner_geom_t           geom,
	output logic                   frame_overlay
);

	frame_state_t state;
	frame_state_t state_nxt;
	logic         en_q;
	logic         last_row;

	assign last_row = (pos.y == height - `FSA_IMG_HW'd1);

	always_comb begin
		state_nxt = state;
		case (state)
			F_ARMED: begin
				if (accept && beat.user) begin
					state_nxt = F_ACTIVE;
				end
			end
			F_ACTIVE: begin
				if (accept && beat.last && last_row) begin
					state_nxt = F_IDLE;
				end
			end
			default: begin
				state_nxt = state;
			end
		endcase
		// fsync restarts from any state
		if (fsync) begin
			state_nxt = F_ARMED;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= F_IDLE;
			en_q  <= 1'b0;
			geom  <= '0;
		end else begin
			state <= state_nxt;
			if (fsync) begin
				en_q <= en_overlay;
				geom <= geom_in;
			end
		end
	end

	// no overlay between frames
	assign frame_overlay = en_q && (state != F_IDLE);

endmodule

// File: hdl/fsa_overlay_top.sv
`timescale 1ns/1ns
`include "fsa_params.svh"

module fsa_overlay_top
	import fsa_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   fsync,
	input  logic                   en_overlay,
	input  logic [`FSA_IMG_HW-1:0] height,
	input  corner_geom_t           geom,
	input  logic                   bound_wr_en,
	input  logic [`FSA_IMG_WW-1:0] bound_wr_addr,
	input  col_bound_t             bound_wr_data,
	input  logic                   s_valid,
	input  pix_beat_t              s_beat,
	output logic                   s_ready,
	output logic                   m_valid,
	output out_word_t              m_word,
	input  logic                   m_ready
);

	logic         accept;
	pix_pos_t     pos;
	corner_geom_t frame_geom;
	logic         frame_overlay;
	col_bound_t   bound;
	logic         fifo_wr;
	out_word_t    fifo_word;
	logic         almost_full;

	assign accept  = s_valid && s_ready;
	assign s_ready = !almost_full;

	frame_ctrl_fsm frame_ctrl_fsm_inst (
		.clk           (clk),
		.resetn        (resetn),
		.fsync         (fsync),
		.en_overlay    (en_overlay),
		.geom_in       (geom),
		.height        (height),
		.accept        (accept),
		.beat          (s_beat),
		.pos           (pos),
		.geom          (frame_geom),
		.frame_overlay (frame_overlay)
	);

	pixel_position_counter pixel_position_counter_inst (
		.clk    (clk),
		.resetn (resetn),
		.accept (accept),
		.beat   (s_beat),
		.pos    (pos)
	);

	column_bound_ram column_bound_ram_inst (
		.clk     (clk),
		.resetn  (resetn),
		.wr_en   (bound_wr_en),
		.wr_addr (bound_wr_addr),
		.wr_data (bound_wr_data),
		.rd_addr (pos.x),
		.bound   (bound)
	);

	corner_overlay_pipe corner_overlay_pipe_inst (
		.clk           (clk),
		.resetn        (resetn),
		.accept        (accept),
		.beat          (s_beat),
		.pos           (pos),
		.frame_overlay (frame_overlay),
		.geom          (frame_geom),
		.bound         (bound),
		.fifo_wr       (fifo_wr),
		.fifo_word     (fifo_word)
	);

	stream_fifo stream_fifo_inst (
		.clk         (clk),
		.resetn      (resetn),
		.wr_en       (fifo_wr),
		.wr_word     (fifo_word),
		.almost_full (almost_full),
		.m_valid     (m_valid),
		.m_word      (m_word),
		.m_ready     (m_ready)
	);

endmodule

// File: hdl/fsa_params.svh
`ifndef FSA_PARAMS_SVH
`define FSA_PARAMS_SVH

// image geometry widths
`define FSA_IMG_WW 12
`define FSA_IMG_HW 12

// pixel widths, one gray channel in and rgb out
`define FSA_CH_W 8
`define FSA_OUT_W 24

// 8 entry output fifo
`define FSA_FIFO_AW 3

// free slots needed to accept, 5 in flight plus one
`define FSA_FIFO_AF 6

// green overlay
`define FSA_OVERLAY_COLOR 24'h00ff00

`endif

// File: hdl/fsa_pkg.sv
`include "fsa_params.svh"

package fsa_pkg;

	typedef struct packed {
		logic [`FSA_CH_W-1:0] data;
		logic                 user;
		logic                 last;
	} pix_beat_t;

	typedef struct packed {
		logic [`FSA_IMG_WW-1:0] x;
		logic [`FSA_IMG_HW-1:0] y;
	} pix_pos_t;

	typedef struct packed {
		logic [`FSA_IMG_HW-1:0] top;
		logic [`FSA_IMG_HW-1:0] bot;
	} col_bound_t;

	// one side of the outline
	typedef struct packed {
		logic                   valid;
		logic [`FSA_IMG_WW-1:0] edge_x;
		logic                   corner_valid;
		logic [`FSA_IMG_WW-1:0] top_x;
		logic [`FSA_IMG_HW-1:0] top_y;
		logic [`FSA_IMG_WW-1:0] bot_x;
		logic [`FSA_IMG_HW-1:0] bot_y;
	} side_geom_t;

	typedef struct packed {
		side_geom_t left;
		side_geom_t right;
	} corner_geom_t;

	typedef struct packed {
		logic [`FSA_OUT_W-1:0] data;
		logic                  user;
		logic                  last;
	} out_word_t;

	typedef enum logic [1:0] {
		F_IDLE,
		F_ARMED,
		F_ACTIVE
	} frame_state_t;

endpackage

// File: hdl/pixel_position_counter.sv
`timescale 1ns/1ns
`include "fsa_params.svh"

module pixel_position_counter
	import fsa_pkg::*;
(
	input  logic      clk,
	input  logic      resetn,
	input  logic      accept,
	input  pix_beat_t beat,
	output pix_pos_t  pos
);

	pix_pos_t cnt;

	// start of frame forces the origin
	assign pos = beat.user ? pix_pos_t'('0) : cnt;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt <= '0;
		end else if (accept) begin
			if (beat.last) begin
				cnt.x <= '0;
				cnt.y <= pos.y + `FSA_IMG_HW'd1;
			end else begin
				cnt.x <= pos.x + `FSA_IMG_WW'd1;
				cnt.y <= pos.y;
			end
		end
	end

endmodule

// File: hdl/stream_fifo.sv
`timescale 1ns/1ns
`include "fsa_params.svh"

module stream_fifo
	import fsa_pkg::*;
(
	input  logic      clk,
	input  logic      resetn,
	input  logic      wr_en,
	input  out_word_t wr_word,
	output logic      almost_full,
	output logic      m_valid,
	output out_word_t m_word,
	input  logic      m_ready
);

	localparam int DEPTH = 1 << `FSA_FIFO_AW;

	out_word_t               mem [0:DEPTH-1];
	logic [`FSA_FIFO_AW:0]   wr_ptr;
	logic [`FSA_FIFO_AW:0]   rd_ptr;
	logic [`FSA_FIFO_AW:0]   count;
	logic                    empty;
	logic                    full;
	logic                    rd_en;

	assign count = wr_ptr - rd_ptr;
	assign empty = (count == '0);
	assign full  = count[`FSA_FIFO_AW];

	// set when fewer free slots than beats that can still arrive
	assign almost_full = (int'(count) > DEPTH - `FSA_FIFO_AF);

	assign rd_en = !empty && (!m_valid || m_ready);

	always_ff @(posedge clk) begin
		if (wr_en && !full) begin
			mem[wr_ptr[`FSA_FIFO_AW-1:0]] <= wr_word;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// output register
	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_valid <= 1'b0;
		end else if (rd_en) begin
			m_valid <= 1'b1;
		end else if (m_ready) begin
			m_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			m_word <= mem[rd_ptr[`FSA_FIFO_AW-1:0]];
		end
	end

endmodule

// File: sim/fsa_overlay_asserts.sv
`timescale 1ns/1ns

module fsa_overlay_asserts
	import fsa_pkg::*;
(
	input logic      clk,
	input logic      resetn,
	input logic      s_ready,
	input logic      m_valid,
	input out_word_t m_word,
	input logic      m_ready
);

	int fail_count = 0;

	property word_stable;
		@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> $stable(m_word);
	endproperty

	property valid_held;
		@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> m_valid;
	endproperty

	// first cycle out of reset
	property reset_state;
		@(posedge clk) $rose(resetn) |-> !m_valid && s_ready;
	endproperty

	a_word_stable: assert property (word_stable) else begin
		fail_count++;
		$error("m_word changed while the output was stalled");
	end

	a_valid_held: assert property (valid_held) else begin
		fail_count++;
		$error("m_valid dropped before the word was taken");
	end

	a_reset_state: assert property (reset_state) else begin
		fail_count++;
		$error("output stream not idle after reset");
	end

endmodule

bind fsa_overlay_top fsa_overlay_asserts fsa_overlay_asserts_inst (
	.clk     (clk),
	.resetn  (resetn),
	.s_ready (s_ready),
	.m_valid (m_valid),
	.m_word  (m_word),
	.m_ready (m_ready)
);

// File: sim/fsa_overlay_tb.sv
`timescale 1ns/1ns
`include "fsa_params.svh"

module fsa_overlay_tb
	import fsa_pkg::*;
();

	localparam int WIDTH = 16;
	localparam int HEIGHT = 8;
	localparam int TIMEOUT = 200;
	localparam logic [31:0] SEED = 32'h9c5fa742;

	logic                   clk;
	logic                   resetn;
	logic                   fsync;
	logic                   en_overlay;
	logic [`FSA_IMG_HW-1:0] height;
	corner_geom_t           geom;
	logic                   bound_wr_en;
	logic [`FSA_IMG_WW-1:0] bound_wr_addr;
	col_bound_t             bound_wr_data;
	logic                   s_valid;
	pix_beat_t              s_beat;
	logic                   s_ready;
	logic                   m_valid;
	out_word_t              m_word;
	logic                   m_ready;

	logic [31:0]  stim_lfsr;
	logic [31:0]  ready_lfsr;
	col_bound_t   bound_tab [0:WIDTH-1];
	out_word_t    exp_q [$];
	frame_state_t m_state;
	logic         m_en;
	int           m_x;
	int           m_y;
	logic         hold_output;
	logic         random_ready;
	logic         saw_not_ready;

	fsa_overlay_top fsa_overlay_top_inst (
		.clk           (clk),
		.resetn        (resetn),
		.fsync         (fsync),
		.en_overlay    (en_overlay),
		.height        (height),
		.geom          (geom),
		.bound_wr_en   (bound_wr_en),
		.bound_wr_addr (bound_wr_addr),
		.bound_wr_data (bound_wr_data),
		.s_valid       (s_valid),
		.s_beat        (s_beat),
		.s_ready       (s_ready),
		.m_valid       (m_valid),
		.m_word        (m_word),
		.m_ready       (m_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h80200003;
		end
		return n;
	endfunction

	function automatic logic [7:0] stim_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[6:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	// corner regions of the outline for one pixel
	function automatic logic in_corner(input int x, input int y);
		col_bound_t b;
		logic lt;
		logic lb;
		logic rt;
		logic rb;
		if (x >= WIDTH) begin
			return 1'b0;
		end
		b = bound_tab[x];
		lt = geom.left.corner_valid && y >= int'(geom.left.top_y) && y < int'(b.top)
			&& x > int'(geom.left.top_x) && x <= int'(geom.left.edge_x);
		lb = geom.left.corner_valid && y <= int'(geom.left.bot_y) && y > int'(b.bot)
			&& x > int'(geom.left.bot_x) && x <= int'(geom.left.edge_x);
		rt = geom.right.corner_valid && y >= int'(geom.right.top_y) && y < int'(b.top)
			&& x >= int'(geom.right.edge_x) && x < int'(geom.right.top_x);
		rb = geom.right.corner_valid && y <= int'(geom.right.bot_y) && y > int'(b.bot)
			&& x >= int'(geom.right.edge_x) && x < int'(geom.right.bot_x);
		return (geom.left.valid && (lt || lb)) || (geom.right.valid && (rt || rb));
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
		$display("Simulation FAILED");
		$fatal(1, "wrong value on %s", name);
	endtask

	task automatic report_error(input string what);
		$display("Error: %s", what);
		$display("Simulation FAILED");
		$fatal(1, "%s", what);
	endtask

	task automatic model_accept(input pix_beat_t b);
		int px;
		int py;
		out_word_t w;
		px = b.user ? 0 : m_x;
		py = b.user ? 0 : m_y;
		w.user = b.user;
		w.last = b.last;
		if (m_en && m_state != F_IDLE && in_corner(px, py)) begin
			w.data = `FSA_OVERLAY_COLOR;
		end else begin
			w.data = {3{b.data}};
		end
		exp_q.push_back(w);
		if (m_state == F_ARMED && b.user) begin
			m_state = F_ACTIVE;
		end else if (m_state == F_ACTIVE && b.last && py == HEIGHT - 1) begin
			m_state = F_IDLE;
		end
		if (b.last) begin
			m_x = 0;
			m_y = py + 1;
		end else begin
			m_x = px + 1;
			m_y = py;
		end
	endtask

	task automatic send_beat(input pix_beat_t b);
		int t;
		if (stim_bits(2) == 8'd0) begin
			s_valid = 1'b0;
			@(posedge clk);
			#10;
		end
		s_valid = 1'b1;
		s_beat = b;
		t = 0;
		// beat is taken at the edge after a negedge that shows s_ready
		@(negedge clk);
		while (!s_ready) begin
			t++;
			if (t > TIMEOUT) begin
				report_error("timeout waiting for s_ready");
			end
			@(negedge clk);
		end
		model_accept(b);
		@(posedge clk);
		#10;
		s_valid = 1'b0;
	endtask

	task automatic send_frame();
		pix_beat_t b;
		for (int y = 0; y < HEIGHT; y++) begin
			for (int x = 0; x < WIDTH; x++) begin
				b.data = stim_bits(8);
				b.user = (x == 0 && y == 0);
				b.last = (x == WIDTH - 1);
				send_beat(b);
			end
		end
	endtask

	task automatic pulse_fsync(input logic en);
		fsync = 1'b1;
		en_overlay = en;
		m_state = F_ARMED;
		m_en = en;
		@(posedge clk);
		#10;
		fsync = 1'b0;
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while (exp_q.size() != 0) begin
			t++;
			if (t > TIMEOUT) begin
				report_error("timeout waiting for the output to drain");
			end
			@(negedge clk);
		end
		@(posedge clk);
		#10;
	endtask

	task automatic load_bounds();
		for (int c = 0; c < WIDTH; c++) begin
			bound_tab[c].top = `FSA_IMG_HW'(2 + c % 3);
			bound_tab[c].bot = `FSA_IMG_HW'(4 + c % 2);
			bound_wr_en = 1'b1;
			bound_wr_addr = `FSA_IMG_WW'(c);
			bound_wr_data = bound_tab[c];
			@(posedge clk);
			#10;
		end
		bound_wr_en = 1'b0;
	endtask

	// output stalls, roughly one cycle in four
	initial begin
		logic b0;
		logic b1;
		ready_lfsr = SEED;
		forever begin
			@(posedge clk);
			#10;
			ready_lfsr = lfsr_next(ready_lfsr);
			b0 = ready_lfsr[0];
			ready_lfsr = lfsr_next(ready_lfsr);
			b1 = ready_lfsr[0];
			m_ready = !hold_output && (!random_ready || b0 || b1);
		end
	end

	// outputs are stable at the negedge before the edge that takes them
	initial begin
		out_word_t exp;
		forever begin
			@(negedge clk);
			if (resetn && !s_ready) begin
				saw_not_ready = 1'b1;
			end
			if (fsa_overlay_top_inst.fsa_overlay_asserts_inst.fail_count != 0) begin
				report_error("a stream protocol assertion failed");
			end
			if (resetn && m_valid && m_ready) begin
				assert (exp_q.size() != 0)
				else report_error("output word with no accepted beat left to match");
				exp = exp_q.pop_front();
				assert (m_word == exp)
				else report_mismatch("m_word", 32'(exp), 32'(m_word));
			end
		end
	end

	initial begin
		resetn = 1'b0;
		fsync = 1'b0;
		en_overlay = 1'b0;
		height = `FSA_IMG_HW'(HEIGHT);
		geom.left = '{1'b1, 12'd5, 1'b1, 12'd2, 12'd1, 12'd2, 12'd6};
		// mirror of the left side in a 16 column frame
		geom.right = '{1'b1, 12'd10, 1'b1, 12'd13, 12'd1, 12'd13, 12'd6};
		bound_wr_en = 1'b0;
		bound_wr_addr = '0;
		bound_wr_data = '0;
		s_valid = 1'b0;
		s_beat = '0;
		m_ready = 1'b0;
		stim_lfsr = SEED;
		m_state = F_IDLE;
		m_en = 1'b0;
		m_x = 0;
		m_y = 0;
		hold_output = 1'b0;
		random_ready = 1'b0;
		saw_not_ready = 1'b0;

		repeat (4) @(posedge clk);
		#10;
		resetn = 1'b1;
		@(negedge clk);
		assert (s_ready == 1'b1) else report_mismatch("s_ready", 32'd1, 32'(s_ready));
		assert (m_valid == 1'b0) else report_mismatch("m_valid", 32'd0, 32'(m_valid));
		repeat (5) @(posedge clk);
		#10;

		load_bounds();
		random_ready = 1'b1;

		// enable level alone, no fsync yet
		en_overlay = 1'b1;
		send_frame();
		wait_drain();

		pulse_fsync(1'b0);
		send_frame();
		wait_drain();

		pulse_fsync(1'b1);
		send_frame();
		wait_drain();

		// back in idle after the last line
		send_frame();
		wait_drain();

		pulse_fsync(1'b1);
		hold_output = 1'b1;
		fork
			send_frame();
			begin
				repeat (30) @(posedge clk);
				hold_output = 1'b0;
			end
		join
		wait_drain();

		assert (saw_not_ready) else report_error("s_ready never dropped while the FIFO filled");
		// every word taken, nothing repeated after the last one
		assert (!m_valid) else report_mismatch("m_valid", 32'd0, 32'(m_valid));
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hdl
hdl/fsa_pkg.sv
hdl/frame_ctrl_fsm.sv
hdl/pixel_position_counter.sv
hdl/column_bound_ram.sv
hdl/corner_overlay_pipe.sv
hdl/stream_fifo.sv
hdl/fsa_overlay_top.sv
sim/fsa_overlay_asserts.sv
sim/fsa_overlay_tb.sv
